/* sources.f */
sram_pkg.sv
sram_req_decode.sv
sram_bus_sequencer.sv
sram_read_assembly.sv
sram_port_top.sv
sram_mem_model.sv
sram_port_sva.sv
tb_sram_port.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_sram_port -o tb_sram_port

out=$(./obj_dir/tb_sram_port 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

/* tb_sram_port.sv */
`timescale 1ns/10ps

module tb_sram_port
    import sram_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;  // covers 256 clear words of up to 6 cycles plus < 3000

    logic              clk;
    logic              rst;
    logic              req;
    op_e               op;
    logic [CHAR_W-1:0] chr;
    logic [PATH_W-1:0] wdata;
    logic              ack;
    logic [PATH_W-1:0] rdata;
    logic [WORD_W-1:0] bus_rdata;
    logic              bus_busy;
    logic              bus_wr_en;
    logic              bus_rd_en;
    logic [3:0]        bus_sel;
    logic [WORD_W-1:0] bus_addr;
    logic [WORD_W-1:0] bus_wdata;
    int                mem_writes;

    int seed = 32'h9226;
    int cycles = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    sram_port_top uut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .op_i        (op),
        .char_i      (chr),
        .wdata_i     (wdata),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .bus_rdata_i (bus_rdata),
        .bus_busy_i  (bus_busy),
        .bus_wr_en_o (bus_wr_en),
        .bus_rd_en_o (bus_rd_en),
        .bus_sel_o   (bus_sel),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata)
    );

    sram_mem_model u_mem (
        .clk           (clk),
        .rst           (rst),
        .wr_en_i       (bus_wr_en),
        .rd_en_i       (bus_rd_en),
        .addr_i        (bus_addr),
        .wdata_i       (bus_wdata),
        .rdata_o       (bus_rdata),
        .busy_o        (bus_busy),
        .write_count_o (mem_writes)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never finished a request", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [PATH_W-1:0] exp,
                                   input logic [PATH_W-1:0] act);
        $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, err_count - errs_before);
        end
    endtask

    // full four-phase exchange with req kept high for hold extra cycles after ack
    task automatic do_request(input op_e op_v, input logic [CHAR_W-1:0] chr_v,
                              input logic [PATH_W-1:0] wd_v, input int hold,
                              output logic [PATH_W-1:0] rd_v);
        @(negedge clk);
        op    = op_v;
        chr   = chr_v;
        wdata = wd_v;
        req   = 1'b1;
        do begin
            @(negedge clk);
        end while (ack !== 1'b1);
        rd_v = rdata;
        repeat (hold) begin
            @(negedge clk);
            if (ack !== 1'b1) report_mismatch("ack_o", PATH_W'(1'b1), PATH_W'(ack));
            if (bus_wr_en || bus_rd_en) begin
                report_mismatch("bus strobe", '0, PATH_W'({bus_wr_en, bus_rd_en}));
            end
        end
        req = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) report_mismatch("ack_o", '0, PATH_W'(ack));
    endtask

    task automatic check_reset_values();
        int errs_before;
        errs_before = err_count;
        if (ack !== 1'b0) report_mismatch("ack_o", '0, PATH_W'(ack));
        if (bus_wr_en !== 1'b0) report_mismatch("bus_wr_en_o", '0, PATH_W'(bus_wr_en));
        if (bus_rd_en !== 1'b0) report_mismatch("bus_rd_en_o", '0, PATH_W'(bus_rd_en));
        if (rdata !== '0) report_mismatch("rdata_o", '0, rdata);
        if (bus_sel !== 4'b1111) report_mismatch("bus_sel_o", PATH_W'(4'b1111), PATH_W'(bus_sel));
        finish_test("reset", errs_before);
    endtask

    task automatic hist_write_read();
        logic [CHAR_W-1:0] c;
        logic [WORD_W-1:0] val;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] got;
        logic [PATH_W-1:0] rd;
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < 6; i++) begin
            c    = CHAR_W'($random(seed));
            val  = $random(seed);
            addr = HIST_BASE + 32'(c) * 4;
            // junk in the upper bits must not reach memory
            do_request(OP_HIST_WRITE, c, {$random(seed), $random(seed), $random(seed), val}, 0, rd);
            got = u_mem.peek_word(addr);
            if (got !== val) report_mismatch("histogram word", PATH_W'(val), PATH_W'(got));
            do_request(OP_HIST_READ, c, '0, 0, rd);
            if (rd !== {96'd0, val}) report_mismatch("rdata_o", {96'd0, val}, rd);
        end
        finish_test("histogram write/read", errs_before);
    endtask

    task automatic path_write_read();
        logic [CHAR_W-1:0] c;
        logic [PATH_W-1:0] path;
        logic [WORD_W-1:0] base;
        logic [WORD_W-1:0] got;
        logic [PATH_W-1:0] rd;
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < 4; i++) begin
            c    = CHAR_W'($random(seed));
            path = {$random(seed), $random(seed), $random(seed), $random(seed)};
            base = CODEBOOK_BASE + 32'(c) * 16;
            do_request(OP_PATH_WRITE, c, path, 0, rd);
            for (int k = 0; k < 4; k++) begin
                got = u_mem.peek_word(base + 32'(4 * k));
                if (got !== path[PATH_W-1-WORD_W*k -: WORD_W]) begin
                    report_mismatch("codebook word", PATH_W'(path[PATH_W-1-WORD_W*k -: WORD_W]),
                                    PATH_W'(got));
                end
            end
            do_request(OP_PATH_READ, c, '0, 0, rd);
            if (rd !== path) report_mismatch("rdata_o", path, rd);
        end
        finish_test("path write/read", errs_before);
    endtask

    task automatic clear_after_writes();
        logic [CHAR_W-1:0] chars [4];
        logic [WORD_W-1:0] snap [4];
        logic [CHAR_W-1:0] c;
        logic [WORD_W-1:0] base;
        logic [WORD_W-1:0] val;
        logic [PATH_W-1:0] rd;
        int writes_before;
        int errs_before;
        errs_before = err_count;
        c    = CHAR_W'($random(seed));
        base = CODEBOOK_BASE + 32'(c) * 16;
        do_request(OP_PATH_WRITE, c, {$random(seed), $random(seed), $random(seed), $random(seed)},
                   0, rd);
        for (int k = 0; k < 4; k++) begin
            snap[k] = u_mem.peek_word(base + 32'(4 * k));
        end
        for (int i = 0; i < 4; i++) begin
            chars[i] = CHAR_W'($random(seed));
            val      = $random(seed) | 1;   // nonzero so the clear is visible
            do_request(OP_HIST_WRITE, chars[i], {96'd0, val}, 0, rd);
        end
        writes_before = mem_writes;
        do_request(OP_CLEAR, CHAR_W'($random(seed)), '0, 0, rd);
        if (mem_writes - writes_before != HIST_WORDS) begin
            report_mismatch("write count", PATH_W'(HIST_WORDS),
                            PATH_W'(mem_writes - writes_before));
        end
        for (int i = 0; i < 4; i++) begin
            do_request(OP_HIST_READ, chars[i], '0, 0, rd);
            if (rd !== '0) report_mismatch("rdata_o", '0, rd);
        end
        for (int k = 0; k < 4; k++) begin
            if (u_mem.peek_word(base + 32'(4 * k)) !== snap[k]) begin
                report_mismatch("codebook word", PATH_W'(snap[k]),
                                PATH_W'(u_mem.peek_word(base + 32'(4 * k))));
            end
        end
        finish_test("clear", errs_before);
    endtask

    task automatic hold_req_after_ack();
        logic [CHAR_W-1:0] c;
        logic [WORD_W-1:0] val;
        logic [PATH_W-1:0] rd;
        int hold;
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < 6; i++) begin
            c    = CHAR_W'($random(seed));
            val  = $random(seed);
            hold = int'($unsigned($random(seed)) % 11);
            do_request(OP_HIST_WRITE, c, {96'd0, val}, hold, rd);
            hold = int'($unsigned($random(seed)) % 11);
            do_request(OP_HIST_READ, c, '0, hold, rd);
            if (rd !== {96'd0, val}) report_mismatch("rdata_o", {96'd0, val}, rd);
        end
        finish_test("handshake back-pressure", errs_before);
    endtask

    initial begin
        rst   = 1'b1;
        req   = 1'b0;
        op    = OP_CLEAR;
        chr   = '0;
        wdata = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_values();
        hist_write_read();
        path_write_read();
        clear_after_writes();
        hold_req_after_ack();

        err_count += uut.u_sva.failures;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sram_port_sva.sv */
`timescale 1ns/10ps

module sram_port_sva (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic ack_o,
    input logic bus_wr_en_o,
    input logic bus_rd_en_o
);

    int failures = 0;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(bus_wr_en_o && bus_rd_en_o))
    else begin
        $error("read and write strobe in the same cycle");
        failures++;
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (rst)
        (bus_wr_en_o || bus_rd_en_o) |=> !(bus_wr_en_o || bus_rd_en_o))
    else begin
        $error("bus strobe longer than one cycle");
        failures++;
    end

    // ack drops only after the client let go of req
    a_ack_release: assert property (@(posedge clk) disable iff (rst)
        $fell(ack_o) |-> !$past(req_i))
    else begin
        $error("ack_o fell while req_i was still high");
        failures++;
    end

    a_quiet_on_ack: assert property (@(posedge clk) disable iff (rst)
        ack_o |-> !(bus_wr_en_o || bus_rd_en_o))
    else begin
        $error("bus strobe while ack_o is high");
        failures++;
    end

endmodule

bind sram_port_top sram_port_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .bus_wr_en_o (bus_wr_en_o),
    .bus_rd_en_o (bus_rd_en_o)
);

/* sram_mem_model.sv */
`timescale 1ns/10ps

module sram_mem_model
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en_i,
    input  logic              rd_en_i,
    input  logic [WORD_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic [WORD_W-1:0] rdata_o,
    output logic              busy_o,
    output int                write_count_o
);

    logic [WORD_W-1:0] mem [logic [WORD_W-1:0]];   // keyed by byte address
    int seed = 32'h9226;
    int busy_left;

    // unwritten words read back a pattern built from the whole address
    function automatic logic [WORD_W-1:0] peek_word(input logic [WORD_W-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'ha5c3_5a3c;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o        <= 1'b0;
            busy_left     <= 0;
            rdata_o       <= '0;
            write_count_o <= 0;
        end else if (wr_en_i || rd_en_i) begin
            busy_o    <= 1'b1;
            busy_left <= 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 busy cycles
            if (wr_en_i) begin
                mem[addr_i] = wdata_i;
                write_count_o <= write_count_o + 1;
            end else begin
                rdata_o <= peek_word(addr_i);
            end
        end else if (busy_left > 0) begin
            if (busy_left == 1) begin
                busy_o <= 1'b0;
            end
            busy_left <= busy_left - 1;
        end
    end

endmodule

/* sram_port_top.sv */
`timescale 1ns/10ps

module sram_port_top
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // client side
    input  logic              req_i,
    input  op_e               op_i,
    input  logic [CHAR_W-1:0] char_i,
    input  logic [PATH_W-1:0] wdata_i,
    output logic              ack_o,
    output logic [PATH_W-1:0] rdata_o,
    // sram bus
    input  logic [WORD_W-1:0] bus_rdata_i,
    input  logic              bus_busy_i,
    output logic              bus_wr_en_o,
    output logic              bus_rd_en_o,
    output logic [3:0]        bus_sel_o,
    output logic [WORD_W-1:0] bus_addr_o,
    output logic [WORD_W-1:0] bus_wdata_o
);

    logic               start;
    logic               write;
    logic [WORD_W-1:0]  first_addr;
    logic [COUNT_W-1:0] word_count;
    logic [PATH_W-1:0]  wbuf;
    logic               done;
    logic               rd_word_valid;

    sram_req_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .op_i         (op_i),
        .char_i       (char_i),
        .wdata_i      (wdata_i),
        .done_i       (done),
        .ack_o        (ack_o),
        .start_o      (start),
        .write_o      (write),
        .first_addr_o (first_addr),
        .word_count_o (word_count),
        .wbuf_o       (wbuf)
    );

    sram_bus_sequencer u_seq (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start),
        .write_i         (write),
        .first_addr_i    (first_addr),
        .word_count_i    (word_count),
        .wbuf_i          (wbuf),
        .bus_busy_i      (bus_busy_i),
        .bus_wr_en_o     (bus_wr_en_o),
        .bus_rd_en_o     (bus_rd_en_o),
        .bus_sel_o       (bus_sel_o),
        .bus_addr_o      (bus_addr_o),
        .bus_wdata_o     (bus_wdata_o),
        .rd_word_valid_o (rd_word_valid),
        .done_o          (done)
    );

    sram_read_assembly u_asm (
        .clk             (clk),
        .rst             (rst),
        .clear_i         (start),
        .rd_word_valid_i (rd_word_valid),
        .bus_rdata_i     (bus_rdata_i),
        .rdata_o         (rdata_o)
    );

endmodule

/* sram_read_assembly.sv */
`timescale 1ns/10ps

module sram_read_assembly
    import sram_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              clear_i,
    input  logic              rd_word_valid_i,
    input  logic [WORD_W-1:0] bus_rdata_i,
    output logic [PATH_W-1:0] rdata_o
);

    // first word of a new request replaces the old result,
    // so rdata_o stays put across write requests
    logic fresh_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fresh_q <= 1'b1;
        end else if (clear_i) begin
            fresh_q <= 1'b1;
        end else if (rd_word_valid_i) begin
            fresh_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_o <= '0;
        end else if (rd_word_valid_i) begin
            if (fresh_q) begin
                rdata_o <= {{(PATH_W-WORD_W){1'b0}}, bus_rdata_i};
            end else begin
                rdata_o <= {rdata_o[PATH_W-WORD_W-1:0], bus_rdata_i};  // shift in low
            end
        end
    end

endmodule

/* sram_bus_sequencer.sv */
`timescale 1ns/10ps

module sram_bus_sequencer
    import sram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  logic               write_i,
    input  logic [WORD_W-1:0]  first_addr_i,
    input  logic [COUNT_W-1:0] word_count_i,
    input  logic [PATH_W-1:0]  wbuf_i,
    input  logic               bus_busy_i,
    output logic               bus_wr_en_o,
    output logic               bus_rd_en_o,
    output logic [3:0]         bus_sel_o,
    output logic [WORD_W-1:0]  bus_addr_o,
    output logic [WORD_W-1:0]  bus_wdata_o,
    output logic               rd_word_valid_o,
    output logic               done_o
);

    seq_state_e state_q, state_d;

    logic [COUNT_W-1:0] cnt_q;
    logic [WORD_W-1:0]  addr_q;
    logic               busy_q;
    logic               word_done;
    logic               last_word;
    logic               strobe;

    // busy falling edge ends the word
    assign word_done = (state_q == SEQ_WAIT) && busy_q && !bus_busy_i;
    assign last_word = (cnt_q + COUNT_W'(1)) == word_count_i;
    assign strobe    = (state_q == SEQ_STROBE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (start_i) begin
                    state_d = SEQ_STROBE;
                end
            end
            SEQ_STROBE: begin
                state_d = SEQ_WAIT;     // single cycle strobe
            end
            SEQ_WAIT: begin
                if (word_done) begin
                    state_d = last_word ? SEQ_IDLE : SEQ_STROBE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= SEQ_IDLE;
            cnt_q   <= '0;
            busy_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q  <= bus_busy_i;
            if (start_i) begin
                cnt_q <= '0;
            end else if (word_done && !last_word) begin
                cnt_q <= cnt_q + COUNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q <= first_addr_i;
        end else if (word_done) begin
            addr_q <= addr_q + WORD_W'(WORD_BYTES);
        end
    end

    assign bus_wr_en_o = strobe && write_i;
    assign bus_rd_en_o = strobe && !write_i;
    assign bus_sel_o   = BUS_SEL_ALL;
    assign bus_addr_o  = addr_q;
    // clear repeats the all zero buffer, paths use all four slots
    assign bus_wdata_o = wbuf_i[cnt_q[1:0]*WORD_W +: WORD_W];

    assign rd_word_valid_o = word_done && !write_i;
    assign done_o          = word_done && last_word;

endmodule

/* sram_req_decode.sv */
`timescale 1ns/10ps

module sram_req_decode
    import sram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  op_e                op_i,
    input  logic [CHAR_W-1:0]  char_i,
    input  logic [PATH_W-1:0]  wdata_i,
    input  logic               done_i,
    output logic               ack_o,
    output logic               start_o,
    output logic               write_o,
    output logic [WORD_W-1:0]  first_addr_o,
    output logic [COUNT_W-1:0] word_count_o,
    output logic [PATH_W-1:0]  wbuf_o
);

    hs_state_e state_q, state_d;
    logic      accept;

    logic [WORD_W-1:0]  hist_addr;
    logic [WORD_W-1:0]  path_addr;
    logic [PATH_W-1:0]  path_wbuf;
    logic               write_d;
    logic [WORD_W-1:0]  addr_d;
    logic [COUNT_W-1:0] count_d;
    logic [PATH_W-1:0]  wbuf_d;

    assign accept = (state_q == HS_IDLE) && req_i;
    assign ack_o  = (state_q == HS_ACK);

    always_comb begin
        state_d = state_q;
        case (state_q)
            HS_IDLE: begin
                if (req_i) begin
                    state_d = HS_RUN;
                end
            end
            HS_RUN: begin
                if (done_i) begin
                    state_d = HS_ACK;
                end
            end
            HS_ACK: begin
                if (!req_i) begin   // client released, drop ack next cycle
                    state_d = HS_IDLE;
                end
            end
            default: state_d = HS_IDLE;
        endcase
    end

    assign hist_addr = HIST_BASE + WORD_W'(char_i) * WORD_W'(WORD_BYTES);
    assign path_addr = CODEBOOK_BASE + WORD_W'(char_i) * WORD_W'(PATH_WORDS * WORD_BYTES);

    // slot k holds the k-th word on the bus, msw of the path goes first
    always_comb begin
        for (int k = 0; k < PATH_WORDS; k++) begin
            path_wbuf[k*WORD_W +: WORD_W] = wdata_i[PATH_W-1-k*WORD_W -: WORD_W];
        end
    end

    always_comb begin
        write_d = 1'b0;
        addr_d  = hist_addr;
        count_d = COUNT_W'(1);
        wbuf_d  = '0;
        case (op_i)
            OP_CLEAR: begin
                write_d = 1'b1;
                addr_d  = HIST_BASE;        // whole table, char ignored
                count_d = COUNT_W'(HIST_WORDS);
            end
            OP_HIST_WRITE: begin
                write_d = 1'b1;
                wbuf_d  = PATH_W'(wdata_i[WORD_W-1:0]);
            end
            OP_PATH_WRITE: begin
                write_d = 1'b1;
                addr_d  = path_addr;
                count_d = COUNT_W'(PATH_WORDS);
                wbuf_d  = path_wbuf;
            end
            OP_PATH_READ: begin
                addr_d  = path_addr;
                count_d = COUNT_W'(PATH_WORDS);
            end
            default: ;  // hist read uses the defaults
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= HS_IDLE;
            start_o <= 1'b0;
        end else begin
            state_q <= state_d;
            start_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_o      <= write_d;
            first_addr_o <= addr_d;
            word_count_o <= count_d;
            wbuf_o       <= wbuf_d;
        end
    end

endmodule

/* sram_pkg.sv */
package sram_pkg;

    // client opcodes
    typedef enum logic [2:0] {
        OP_CLEAR,
        OP_HIST_READ,
        OP_HIST_WRITE,
        OP_PATH_WRITE,
        OP_PATH_READ
    } op_e;

    // four-phase client handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_RUN,
        HS_ACK
    } hs_state_e;

    // bus word sequencing
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STROBE,
        SEQ_WAIT
    } seq_state_e;

    localparam int WORD_W     = 32;
    localparam int PATH_W     = 128;
    localparam int CHAR_W     = 8;
    localparam int HIST_WORDS = 256;
    localparam int PATH_WORDS = 4;
    localparam int WORD_BYTES = 4;
    localparam int COUNT_W    = 9;    // holds HIST_WORDS

    // sram memory map, byte addresses
    localparam logic [WORD_W-1:0] HIST_BASE     = 32'h33000000;
    localparam logic [WORD_W-1:0] CODEBOOK_BASE = 32'h33001000;

    localparam logic [3:0] BUS_SEL_ALL = 4'b1111;

endpackage
